/* flist.f */
+incdir+tb
source/btb_pkg.sv
source/btb_table.sv
source/btb_lookup.sv
source/btb_resolve.sv
source/btb_predictor.sv
tb/tb_btb_predictor.sv

/* run.sh */
#!/bin/sh
# build and run the BTB testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing -f flist.f --top-module tb_btb_predictor \
    -o tb_btb_predictor \
    && ./obj_dir/tb_btb_predictor > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log

grep -q "TESTBENCH FAILED" sim.log && exit 1

exit 0

/* source/btb_lookup.sv */
// BTB fetch-side lookup

`timescale 1ns/1ps
`default_nettype none

module btb_lookup #(
    parameter int ENTRIES = 16
) (
    input  btb_pkg::pc_t               fetch_pc,

    // table read port
    output logic [$clog2(ENTRIES)-1:0] rd_index,
    input  btb_pkg::btb_entry_t        rd_entry,

    output btb_pkg::pred_t             pred
);

    localparam int IDX_W = $clog2(ENTRIES);

    logic         hit;
    logic         pred_taken;
    btb_pkg::pc_t fall_pc;

    // index is the low word-address bits of the pc
    assign rd_index = fetch_pc[2 +: IDX_W];

    always_comb begin
        hit        = rd_entry.valid && (rd_entry.tag == fetch_pc[31:2]);
        pred_taken = hit && (rd_entry.hist >= btb_pkg::HIST_TAKEN_MIN);
        fall_pc    = fetch_pc + btb_pkg::INSTR_BYTES;

        pred.hit = hit;

        // miss reports a cleared history
        if (hit) begin
            pred.hist = rd_entry.hist;
        end else begin
            pred.hist = '0;
        end

        if (pred_taken) begin
            pred.next_pc = {rd_entry.target, 2'b00};
        end else begin
            pred.next_pc = fall_pc;
        end
    end

endmodule

`default_nettype wire

/* source/btb_pkg.sv */
// Branch target buffer types

`default_nettype none

package btb_pkg;

    // byte address of an instruction
    typedef logic [31:0] pc_t;

    // pc without the two low bits, used for tags and stored targets
    typedef logic [29:0] word_addr_t;

    // saturating 2-bit branch history
    typedef logic [1:0] hist_t;

    // kind of control-flow instruction at execute
    typedef logic [1:0] cf_kind_t;

    // conditional branch, target is pc + imm
    localparam cf_kind_t CF_BRANCH = 2'd0;
    // always taken, target is pc + imm
    localparam cf_kind_t CF_JAL    = 2'd1;
    // always taken, target is the alu result
    localparam cf_kind_t CF_JALR   = 2'd2;

    // fall-through step
    localparam pc_t   INSTR_BYTES    = 32'd4;
    // history values from here up predict taken
    localparam hist_t HIST_TAKEN_MIN = 2'd2;
    localparam hist_t HIST_MAX       = 2'd3;

    // one table entry
    typedef struct packed {
        logic       valid;
        word_addr_t tag;
        word_addr_t target;
        hist_t      hist;
    } btb_entry_t;

    // fetch-side lookup result
    typedef struct packed {
        pc_t   next_pc;
        hist_t hist;
        logic  hit;
    } pred_t;

    // one resolved instruction from execute
    typedef struct packed {
        logic     valid;
        cf_kind_t kind;
        // branch condition, ignored for jumps
        logic     taken;
        pc_t      pc;
        // sign-extended immediate
        pc_t      imm;
        pc_t      alu_out;
        // prediction that travelled with the instruction
        pc_t      pred_next_pc;
        // history returned at fetch
        hist_t    hist;
    } resolve_t;

endpackage

`default_nettype wire

/* source/btb_predictor.sv */
// Branch target buffer top

`timescale 1ns/1ps
`default_nettype none

module btb_predictor #(
    // power of two, at least 2
    parameter int ENTRIES = 16
) (
    input  logic                clk,
    input  logic                rst_l,

    // fetch side
    input  btb_pkg::pc_t        fetch_pc,
    output btb_pkg::pred_t      pred,

    // execute side
    input  btb_pkg::resolve_t   res,
    output logic                redirect,
    output btb_pkg::pc_t        redirect_pc
);

    localparam int IDX_W = $clog2(ENTRIES);

    // read path
    logic [IDX_W-1:0]    rd_index;
    btb_pkg::btb_entry_t rd_entry;

    // write path
    logic                wr_en;
    logic [IDX_W-1:0]    wr_index;
    btb_pkg::btb_entry_t wr_entry;

    btb_table #(
        .ENTRIES (ENTRIES)
    ) u_table (
        .clk      (clk),
        .rst_l    (rst_l),
        .rd_index (rd_index),
        .rd_entry (rd_entry),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_entry (wr_entry)
    );

    btb_lookup #(
        .ENTRIES (ENTRIES)
    ) u_lookup (
        .fetch_pc (fetch_pc),
        .rd_index (rd_index),
        .rd_entry (rd_entry),
        .pred     (pred)
    );

    btb_resolve #(
        .ENTRIES (ENTRIES)
    ) u_resolve (
        .res         (res),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wr_en       (wr_en),
        .wr_index    (wr_index),
        .wr_entry    (wr_entry)
    );

endmodule

`default_nettype wire

/* source/btb_resolve.sv */
// BTB execute-side resolution

`timescale 1ns/1ps
`default_nettype none

module btb_resolve #(
    parameter int ENTRIES = 16
) (
    input  btb_pkg::resolve_t          res,

    // redirect back to fetch
    output logic                       redirect,
    output btb_pkg::pc_t               redirect_pc,

    // table write port
    output logic                       wr_en,
    output logic [$clog2(ENTRIES)-1:0] wr_index,
    output btb_pkg::btb_entry_t        wr_entry
);

    localparam int IDX_W = $clog2(ENTRIES);

    btb_pkg::pc_t   target;
    btb_pkg::pc_t   fall_pc;
    btb_pkg::pc_t   actual_pc;
    logic           actual_taken;
    btb_pkg::hist_t new_hist;

    // target by control-flow kind
    always_comb begin
        case (res.kind)
            btb_pkg::CF_JALR: begin
                target = res.alu_out;
            end
            default: begin
                target = res.pc + res.imm;
            end
        endcase
        // instruction addresses are word aligned
        target[1:0] = 2'b00;
    end

    // jumps are always taken
    always_comb begin
        if (res.kind == btb_pkg::CF_BRANCH) begin
            actual_taken = res.taken;
        end else begin
            actual_taken = 1'b1;
        end
    end

    assign fall_pc = res.pc + btb_pkg::INSTR_BYTES;

    always_comb begin
        if (actual_taken) begin
            actual_pc = target;
        end else begin
            actual_pc = fall_pc;
        end
    end

    // mispredict when the real next pc differs from the one fetched
    assign redirect    = res.valid && (actual_pc != res.pred_next_pc);
    assign redirect_pc = actual_pc;

    // saturating 2-bit counter
    always_comb begin
        if (actual_taken) begin
            if (res.hist == btb_pkg::HIST_MAX) begin
                new_hist = btb_pkg::HIST_MAX;
            end else begin
                new_hist = res.hist + 2'd1;
            end
        end else begin
            if (res.hist == '0) begin
                new_hist = '0;
            end else begin
                new_hist = res.hist - 2'd1;
            end
        end
    end

    // every valid resolve replaces the entry at its index
    assign wr_en    = res.valid;
    assign wr_index = res.pc[2 +: IDX_W];

    always_comb begin
        wr_entry.valid  = 1'b1;
        wr_entry.tag    = res.pc[31:2];
        wr_entry.target = target[31:2];
        wr_entry.hist   = new_hist;
    end

endmodule

`default_nettype wire

/* source/btb_table.sv */
// Direct-mapped BTB storage

`timescale 1ns/1ps
`default_nettype none

module btb_table #(
    parameter int ENTRIES = 16
) (
    input  logic                       clk,
    input  logic                       rst_l,

    // combinational read port
    input  logic [$clog2(ENTRIES)-1:0] rd_index,
    output btb_pkg::btb_entry_t        rd_entry,

    // clocked write port
    input  logic                       wr_en,
    input  logic [$clog2(ENTRIES)-1:0] wr_index,
    input  btb_pkg::btb_entry_t        wr_entry
);

    // valid bits, cleared at reset
    logic [ENTRIES-1:0] valid_q;

    // payload arrays
    btb_pkg::word_addr_t tag_mem    [ENTRIES];
    btb_pkg::word_addr_t target_mem [ENTRIES];
    btb_pkg::hist_t      hist_mem   [ENTRIES];

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_index] <= wr_entry.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index]    <= wr_entry.tag;
            target_mem[wr_index] <= wr_entry.target;
            hist_mem[wr_index]   <= wr_entry.hist;
        end
    end

    // a read in the cycle of a write still returns the old entry
    always_comb begin
        rd_entry.valid  = valid_q[rd_index];
        rd_entry.tag    = tag_mem[rd_index];
        rd_entry.target = target_mem[rd_index];
        rd_entry.hist   = hist_mem[rd_index];
    end

endmodule

`default_nettype wire

/* tb/tb_btb_tasks.svh */
// BTB directed test tasks

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

task automatic draw_random(output logic [31:0] value);
    rng_state = xorshift32(rng_state);
    value     = rng_state;
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
        $display("mismatch %s: expected %b, actual %b", name, expected, actual);
        error_count++;
    end
endtask

task automatic check_pc(input string name, input btb_pkg::pc_t expected,
                        input btb_pkg::pc_t actual);
    check_count++;
    if (actual !== expected) begin
        $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        error_count++;
    end
endtask

task automatic check_pred(input string name, input btb_pkg::pred_t expected,
                          input btb_pkg::pred_t actual);
    check_count++;
    if (actual !== expected) begin
        $display("mismatch %s: expected next %h hist %0d hit %b, actual next %h hist %0d hit %b",
                 name, expected.next_pc, expected.hist, expected.hit,
                 actual.next_pc, actual.hist, actual.hit);
        error_count++;
    end
endtask

function automatic btb_pkg::pred_t make_pred(input btb_pkg::pc_t next_pc,
                                             input btb_pkg::hist_t hist, input logic hit);
    btb_pkg::pred_t p;
    p.next_pc = next_pc;
    p.hist    = hist;
    p.hit     = hit;
    return p;
endfunction

function automatic btb_pkg::resolve_t make_res(
    input btb_pkg::cf_kind_t kind, input logic taken, input btb_pkg::pc_t pc,
    input btb_pkg::pc_t imm, input btb_pkg::pc_t alu_out,
    input btb_pkg::pc_t pred_next_pc, input btb_pkg::hist_t hist);
    btb_pkg::resolve_t r;
    r.valid        = 1'b1;
    r.kind         = kind;
    r.taken        = taken;
    r.pc           = pc;
    r.imm          = imm;
    r.alu_out      = alu_out;
    r.pred_next_pc = pred_next_pc;
    r.hist         = hist;
    return r;
endfunction

// one cycle of lookup and resolve checked against the model
task automatic run_cycle(input string name, input btb_pkg::pc_t pc,
                         input btb_pkg::resolve_t r);
    btb_pkg::pred_t exp_pred;
    btb_pkg::pc_t   exp_pc;
    logic           exp_redirect;
    fetch_pc = pc;
    res      = r;
    // combinational outputs have settled by mid-cycle
    @(negedge clk);
    exp_pred        = model_pred(pc);
    exp_pc          = model_actual_pc(r);
    exp_redirect    = r.valid && (exp_pc != r.pred_next_pc);
    obs_pred        = pred;
    obs_redirect    = redirect;
    obs_redirect_pc = redirect_pc;
    check_pred({name, " model pred"}, exp_pred, obs_pred);
    check_flag({name, " model redirect"}, exp_redirect, obs_redirect);
    if (r.valid) begin
        check_pc({name, " model redirect_pc"}, exp_pc, obs_redirect_pc);
    end
    @(posedge clk);
    if (r.valid) begin
        model_update(r);
    end
    #(DRIVE_DELAY);
endtask

// fetch the pc and resolve it in the next cycle with the expected prediction
task automatic lookup_then_resolve(input string name, input btb_pkg::cf_kind_t kind,
                                   input logic taken, input btb_pkg::pc_t pc,
                                   input btb_pkg::pc_t imm, input btb_pkg::pc_t alu_out);
    btb_pkg::pred_t p;
    run_cycle({name, " lookup"}, pc, IDLE_RES);
    p = model_pred(pc);
    run_cycle(name, pc, make_res(kind, taken, pc, imm, alu_out, p.next_pc, p.hist));
endtask

task automatic test_reset_state();
    btb_pkg::pc_t      pcs [4];
    btb_pkg::resolve_t r;
    pcs = '{32'h0000_0000, 32'h0000_0100, 32'h8000_0040, 32'hffff_fffc};
    // a jump that would redirect if it were valid
    r       = make_res(btb_pkg::CF_JAL, 1'b1, 32'h0000_0010, 32'h0000_0100, 32'h0, 32'h0, 2'd0);
    r.valid = 1'b0;
    foreach (pcs[k]) begin
        run_cycle("reset", pcs[k], r);
        check_pred("reset miss", make_pred(pcs[k] + btb_pkg::INSTR_BYTES, 2'd0, 1'b0), obs_pred);
        check_flag("reset redirect", 1'b0, obs_redirect);
    end
endtask

task automatic test_branch_training();
    lookup_then_resolve("train first", btb_pkg::CF_BRANCH, 1'b1, TRAIN_PC, TRAIN_IMM, 32'h0);
    check_flag("train first redirect", 1'b1, obs_redirect);
    check_pc("train first redirect_pc", TRAIN_TGT, obs_redirect_pc);
    run_cycle("train hist 1", TRAIN_PC, IDLE_RES);
    check_pred("train hist 1", make_pred(TRAIN_PC + btb_pkg::INSTR_BYTES, 2'd1, 1'b1), obs_pred);
    lookup_then_resolve("train second", btb_pkg::CF_BRANCH, 1'b1, TRAIN_PC, TRAIN_IMM, 32'h0);
    check_flag("train second redirect", 1'b1, obs_redirect);
    run_cycle("train hist 2", TRAIN_PC, IDLE_RES);
    check_pred("train hist 2", make_pred(TRAIN_TGT, 2'd2, 1'b1), obs_pred);
    lookup_then_resolve("train third", btb_pkg::CF_BRANCH, 1'b1, TRAIN_PC, TRAIN_IMM, 32'h0);
    check_flag("train third redirect", 1'b0, obs_redirect);
endtask

task automatic test_saturation();
    repeat (2) begin
        lookup_then_resolve("sat taken", btb_pkg::CF_BRANCH, 1'b1, TRAIN_PC, TRAIN_IMM, 32'h0);
        check_flag("sat taken redirect", 1'b0, obs_redirect);
    end
    run_cycle("sat hold", TRAIN_PC, IDLE_RES);
    check_pred("sat hold", make_pred(TRAIN_TGT, btb_pkg::HIST_MAX, 1'b1), obs_pred);
    // single not-taken drops to 2 and still predicts the target
    lookup_then_resolve("sat not taken", btb_pkg::CF_BRANCH, 1'b0, TRAIN_PC, TRAIN_IMM, 32'h0);
    check_flag("sat not taken redirect", 1'b1, obs_redirect);
    check_pc("sat not taken redirect_pc", TRAIN_PC + btb_pkg::INSTR_BYTES, obs_redirect_pc);
    run_cycle("sat hyst", TRAIN_PC, IDLE_RES);
    check_pred("sat hyst", make_pred(TRAIN_TGT, 2'd2, 1'b1), obs_pred);
    repeat (3) begin
        lookup_then_resolve("sat drain", btb_pkg::CF_BRANCH, 1'b0, TRAIN_PC, TRAIN_IMM, 32'h0);
    end
    run_cycle("sat floor", TRAIN_PC, IDLE_RES);
    check_pred("sat floor", make_pred(TRAIN_PC + btb_pkg::INSTR_BYTES, 2'd0, 1'b1), obs_pred);
endtask

task automatic test_jumps();
    // backward jal with the branch condition low
    lookup_then_resolve("jal", btb_pkg::CF_JAL, 1'b0, 32'h0000_2008, 32'hffff_ff00, 32'h0);
    check_flag("jal redirect", 1'b1, obs_redirect);
    check_pc("jal redirect_pc", 32'h0000_1f08, obs_redirect_pc);
    run_cycle("jal lookup", 32'h0000_2008, IDLE_RES);
    check_pred("jal lookup", make_pred(32'h0000_200c, 2'd1, 1'b1), obs_pred);
    lookup_then_resolve("jalr", btb_pkg::CF_JALR, 1'b0, 32'h0000_3014, 32'h0000_0010,
                        32'h0000_5677);
    check_flag("jalr redirect", 1'b1, obs_redirect);
    check_pc("jalr redirect_pc", 32'h0000_5674, obs_redirect_pc);
endtask

task automatic test_aliasing();
    // both pcs land on index 12
    lookup_then_resolve("alias a", btb_pkg::CF_BRANCH, 1'b1, 32'h0000_4030, 32'h0000_0040, 32'h0);
    run_cycle("alias a lookup", 32'h0000_4030, IDLE_RES);
    check_pred("alias a hit", make_pred(32'h0000_4034, 2'd1, 1'b1), obs_pred);
    lookup_then_resolve("alias b", btb_pkg::CF_BRANCH, 1'b1, 32'h0000_8030, 32'hffff_fff0, 32'h0);
    check_pred("alias b miss", make_pred(32'h0000_8034, 2'd0, 1'b0), obs_pred);
    run_cycle("alias a again", 32'h0000_4030, IDLE_RES);
    check_pred("alias a evicted", make_pred(32'h0000_4034, 2'd0, 1'b0), obs_pred);
    run_cycle("alias b lookup", 32'h0000_8030, IDLE_RES);
    check_pred("alias b hit", make_pred(32'h0000_8034, 2'd1, 1'b1), obs_pred);
endtask

task automatic test_random_traffic();
    btb_pkg::pc_t      pcs [4];
    btb_pkg::resolve_t r;
    btb_pkg::pred_t    p;
    logic [31:0]       r0;
    logic [31:0]       r1;
    logic [31:0]       r2;
    // first two share an index
    pcs = '{32'h0000_0100, 32'h0000_0140, 32'h0000_0104, 32'h0000_0208};
    for (int n = 0; n < RANDOM_STEPS; n++) begin
        draw_random(r0);
        draw_random(r1);
        draw_random(r2);
        r         = IDLE_RES;
        r.valid   = r0[0];
        r.taken   = r0[1];
        r.kind    = 2'(r0[7:4] % 4'd3);
        r.pc      = pcs[r0[9:8]];
        r.imm     = {{20{r1[11]}}, r1[11:1], 1'b0};
        r.alu_out = r2;
        p         = model_pred(r.pc);
        // either what fetch would have seen or a stale prediction
        if (r0[2]) begin
            r.pred_next_pc = p.next_pc;
            r.hist         = p.hist;
        end else begin
            r.pred_next_pc = pcs[r0[15:14]] + btb_pkg::INSTR_BYTES;
            r.hist         = r0[11:10];
        end
        run_cycle("random", pcs[r0[13:12]], r);
    end
endtask

/* tb/tb_btb_predictor.sv */
// BTB predictor testbench

`timescale 1ns/1ps
`default_nettype none

module tb_btb_predictor;

    localparam int ENTRIES         = 16;
    localparam int IDX_W           = $clog2(ENTRIES);
    localparam int CLK_PERIOD      = 40;
    localparam int DRIVE_DELAY     = 2;
    localparam int RESET_CYCLES    = 8;
    // upper bound on the cycles used by all directed tests
    localparam int DIRECTED_CYCLES = 60;
    localparam int RANDOM_STEPS    = 200;
    localparam int MARGIN_CYCLES   = 20;
    localparam int TIMEOUT_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_STEPS
                                     + MARGIN_CYCLES;

    localparam btb_pkg::pc_t      WORD_MASK = 32'hffff_fffc;
    localparam btb_pkg::resolve_t IDLE_RES  = '0;

    // branch used by the training and saturation tests
    localparam btb_pkg::pc_t TRAIN_PC  = 32'h0000_1040;
    localparam btb_pkg::pc_t TRAIN_IMM = 32'h0000_0200;
    localparam btb_pkg::pc_t TRAIN_TGT = 32'h0000_1240;

    logic              clk;
    logic              rst_l;
    btb_pkg::pc_t      fetch_pc;
    btb_pkg::pred_t    pred;
    btb_pkg::resolve_t res;
    logic              redirect;
    btb_pkg::pc_t      redirect_pc;

    // outputs captured mid-cycle by run_cycle
    btb_pkg::pred_t    obs_pred;
    logic              obs_redirect;
    btb_pkg::pc_t      obs_redirect_pc;

    int                error_count;
    int                check_count;
    logic [31:0]       rng_state;

    // reference table
    logic                model_valid  [ENTRIES];
    btb_pkg::word_addr_t model_tag    [ENTRIES];
    btb_pkg::word_addr_t model_target [ENTRIES];
    btb_pkg::hist_t      model_hist   [ENTRIES];

    btb_predictor #(
        .ENTRIES (ENTRIES)
    ) dut (
        .clk         (clk),
        .rst_l       (rst_l),
        .fetch_pc    (fetch_pc),
        .pred        (pred),
        .res         (res),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: test sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic logic [IDX_W-1:0] model_index(input btb_pkg::pc_t pc);
        return pc[2 +: IDX_W];
    endfunction

    function automatic btb_pkg::pc_t model_target_pc(input btb_pkg::resolve_t r);
        if (r.kind == btb_pkg::CF_JALR) begin
            return r.alu_out & WORD_MASK;
        end
        return (r.pc + r.imm) & WORD_MASK;
    endfunction

    function automatic btb_pkg::pc_t model_actual_pc(input btb_pkg::resolve_t r);
        if (r.kind != btb_pkg::CF_BRANCH || r.taken) begin
            return model_target_pc(r);
        end
        return r.pc + btb_pkg::INSTR_BYTES;
    endfunction

    function automatic btb_pkg::pred_t model_pred(input btb_pkg::pc_t pc);
        btb_pkg::pred_t   p;
        logic [IDX_W-1:0] i;
        i         = model_index(pc);
        p.hit     = model_valid[i] && (model_tag[i] == pc[31:2]);
        p.hist    = p.hit ? model_hist[i] : 2'd0;
        p.next_pc = pc + btb_pkg::INSTR_BYTES;
        if (p.hit && model_hist[i] >= btb_pkg::HIST_TAKEN_MIN) begin
            p.next_pc = {model_target[i], 2'b00};
        end
        return p;
    endfunction

    function automatic void model_update(input btb_pkg::resolve_t r);
        logic [IDX_W-1:0] i;
        logic             taken;
        btb_pkg::hist_t   h;
        btb_pkg::pc_t     tgt;
        i     = model_index(r.pc);
        taken = (r.kind != btb_pkg::CF_BRANCH) || r.taken;
        tgt   = model_target_pc(r);
        h     = r.hist;
        if (taken && h != btb_pkg::HIST_MAX) begin
            h = h + 2'd1;
        end else if (!taken && h != 2'd0) begin
            h = h - 2'd1;
        end
        model_valid[i]  = 1'b1;
        model_tag[i]    = r.pc[31:2];
        model_target[i] = tgt[31:2];
        model_hist[i]   = h;
    endfunction

    `include "tb_btb_tasks.svh"

    initial begin
        rst_l           = 1'b0;
        fetch_pc        = '0;
        res             = '0;
        obs_pred        = '0;
        obs_redirect    = 1'b0;
        obs_redirect_pc = '0;
        error_count     = 0;
        check_count     = 0;
        rng_state       = 32'hbf4cfa50;
        model_valid     = '{default: 1'b0};
        model_tag       = '{default: '0};
        model_target    = '{default: '0};
        model_hist      = '{default: '0};

        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst_l = 1'b1;

        test_reset_state();
        test_branch_training();
        test_saturation();
        test_jumps();
        test_aliasing();
        test_random_traffic();

        res = IDLE_RES;
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
